// ==== dmm_pkg.sv ====
/*
  dmm front end shared definitions
  register map, field widths, output modes and the safe pin values
*/

package dmm_pkg;

  ////////////////////////////////////////
  // widths and types

  typedef logic [7:0]  addr_t;
  typedef logic [23:0] data_t;
  // from the top: himux 2, himux, az mux, each as a0 a1 a2 en
  typedef logic [11:0] mux_ctl_t;
  typedef logic [7:0]  mon_t;
  typedef logic [1:0]  mode_t;
  typedef logic [15:0] period_t;
  // one mux field, a0 a1 a2 en
  typedef logic [3:0]  mux_field_t;
  // spi bit counter, wide enough to see overlong frames
  typedef logic [5:0]  count_t;

  // spi frame shape
  localparam count_t addr_bits  = 6'd8;
  localparam count_t frame_bits = 6'd32;

  ////////////////////////////////////////
  // register addresses

  localparam addr_t addr_led       = 8'd1;
  localparam addr_t addr_spi_mux   = 8'd2;
  localparam addr_t addr_mode      = 8'd3;
  localparam addr_t addr_mux_ctl   = 8'd4;
  localparam addr_t addr_az_period = 8'd5;

  // output modes
  localparam mode_t mode_off   = 2'd0;
  localparam mode_t mode_reg   = 2'd1;
  localparam mode_t mode_count = 2'd2;
  localparam mode_t mode_az    = 2'd3;

  // safe values, all muxes disabled
  localparam mux_ctl_t mux_ctl_safe = 12'h000;
  localparam mon_t     mon_safe     = 8'h00;

  // az mux codes: s1 is the zero reference, s2 the signal
  localparam mux_field_t az_code_zero   = 4'b0001;
  localparam mux_field_t az_code_signal = 4'b1001;

  // 4094 strobe latches on high
  localparam logic cs_polarity_4094 = 1'b1;

endpackage

// ==== spi_reg_bank.sv ====
/*
  spi register bank
  oversampled spi slave, 32 bit frame of address and data
  shifts the old register value out on miso and commits the new one on cs rise
*/

`timescale 1ns/1ns

module spi_reg_bank import dmm_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     sclk,
  input  logic     cs,
  input  logic     mosi,
  output logic     dout,
  output logic     led,
  output logic     spi_mux_en,
  output mode_t    mode,
  output mux_ctl_t mux_ctl_reg,
  output period_t  az_period
);

  logic [1:0] sclk_sync;
  logic [1:0] cs_sync;
  logic [1:0] mosi_sync;
  logic       sclk_q;
  logic       cs_q;
  logic       sclk_rise;
  logic       sclk_fall;
  logic       cs_active;
  logic       cs_rise;
  count_t     bit_count;
  logic [31:0] in_sr;
  logic [31:0] shift_next;
  data_t      out_sr;
  data_t      rd_value;
  data_t      reg_led;
  data_t      reg_spi_mux;
  data_t      reg_mode;
  data_t      reg_mux_ctl;
  data_t      reg_az_period;

  ////////////////////////////////////////
  // pin synchronizers and edge detect

  // idle bus is sclk low, cs high
  always_ff @(posedge clk) begin
    if (reset) begin
      sclk_sync <= 2'b00;
      cs_sync   <= 2'b11;
      sclk_q    <= 1'b0;
      cs_q      <= 1'b1;
    end else begin
      sclk_sync <= {sclk_sync[0], sclk};
      cs_sync   <= {cs_sync[0], cs};
      sclk_q    <= sclk_sync[1];
      cs_q      <= cs_sync[1];
    end
  end

  always_ff @(posedge clk) begin
    mosi_sync <= {mosi_sync[0], mosi};
  end

  assign sclk_rise = sclk_sync[1] & ~sclk_q;
  assign sclk_fall = ~sclk_sync[1] & sclk_q;
  assign cs_active = ~cs_sync[1];
  assign cs_rise   = cs_sync[1] & ~cs_q;

  ////////////////////////////////////////
  // frame shifting

  // mode 0, mosi sampled on the rising edge, msb first
  assign shift_next = {in_sr[30:0], mosi_sync[1]};

  always_ff @(posedge clk) begin
    if (cs_active && sclk_rise) begin
      in_sr <= shift_next;
    end
  end

  // old value of the addressed register, looked up as bit 8 lands
  always_comb begin
    case (addr_t'(shift_next[7:0]))
      addr_led:       rd_value = reg_led;
      addr_spi_mux:   rd_value = reg_spi_mux;
      addr_mode:      rd_value = reg_mode;
      addr_mux_ctl:   rd_value = reg_mux_ctl;
      addr_az_period: rd_value = reg_az_period;
      default:        rd_value = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset || !cs_active) begin
      bit_count <= '0;
      out_sr    <= '0;
    end else if (sclk_rise) begin
      // saturate so an overlong frame never looks like 32 bits
      if (bit_count != '1) begin
        bit_count <= bit_count + 1'b1;
      end
      if (bit_count == addr_bits - 1'b1) begin
        out_sr <= rd_value;
      end
    end else if (sclk_fall && bit_count > addr_bits) begin
      // next miso bit goes out on the falling edge
      out_sr <= {out_sr[22:0], 1'b0};
    end
  end

  assign dout = out_sr[23];

  ////////////////////////////////////////
  // register write on cs rise

  always_ff @(posedge clk) begin
    if (reset) begin
      reg_led       <= '0;
      reg_spi_mux   <= '0;
      reg_mode      <= '0;
      reg_mux_ctl   <= '0;
      reg_az_period <= '0;
    end else if (cs_rise && bit_count == frame_bits) begin
      case (addr_t'(in_sr[31:24]))
        addr_led:       reg_led       <= in_sr[23:0];
        addr_spi_mux:   reg_spi_mux   <= in_sr[23:0];
        addr_mode:      reg_mode      <= in_sr[23:0];
        addr_mux_ctl:   reg_mux_ctl   <= in_sr[23:0];
        addr_az_period: reg_az_period <= in_sr[23:0];
        // unknown address, write dropped
        default: ;
      endcase
    end
  end

  assign led         = reg_led[0];
  assign spi_mux_en  = |reg_spi_mux;
  assign mode        = mode_t'(reg_mode[1:0]);
  assign mux_ctl_reg = mux_ctl_t'(reg_mux_ctl[11:0]);
  assign az_period   = period_t'(reg_az_period[15:0]);

endmodule

// ==== spi_mux.sv ====
/*
  spi mux
  routes the host spi onto the 4094 chain while cs2 is asserted
  and picks the miso source
*/

`timescale 1ns/1ns

module spi_mux import dmm_pkg::*; (
  input  logic spi_mux_en,
  input  logic cs2,
  input  logic sclk,
  input  logic mosi,
  input  logic dout,
  input  logic vec_miso,
  output logic miso,
  output logic strobe_4094,
  output logic clk_4094,
  output logic data_4094
);

  logic route_4094;

  // cs2 is active low, and only counts when the register enables it
  assign route_4094 = spi_mux_en & ~cs2;

  // host clock and data straight through, held low when idle
  assign clk_4094  = route_4094 & sclk;
  assign data_4094 = route_4094 & mosi;

  // strobe follows cs2 with the 4094 polarity applied
  assign strobe_4094 = route_4094 ? (cs2 ^ cs_polarity_4094) : ~cs_polarity_4094;

  // readback from the end of the chain, else the register bank
  assign miso = route_4094 ? vec_miso : dout;

endmodule

// ==== az_modulator.sv ====
/*
  auto-zero modulator
  alternates the az mux between zero reference and signal,
  each phase held for period+1 cycles, precharge switch on in the zero phase
*/

`timescale 1ns/1ns

module az_modulator import dmm_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     enable,
  input  period_t  period,
  output mux_ctl_t az_mux_ctl,
  output logic     pc_sw,
  output mon_t     mon
);

  period_t count;
  // 0 = zero phase, 1 = signal phase
  logic    phase;
  logic    pc_next;
  logic    pc_q;

  ////////////////////////////////////////
  // phase sequencer

  // held at the start of the zero phase while disabled
  always_ff @(posedge clk) begin
    if (reset || !enable) begin
      count <= '0;
      phase <= 1'b0;
    end else if (count >= period) begin
      // last cycle of this phase
      count <= '0;
      phase <= ~phase;
    end else begin
      count <= count + 1'b1;
    end
  end

  ////////////////////////////////////////
  // outputs

  // both hi muxes stay disabled, only the az field moves
  assign az_mux_ctl = {mux_ctl_safe[11:4], phase ? az_code_signal : az_code_zero};

  assign pc_next = enable & ~phase;

  // the mux pins see az_mux_ctl one cycle late through the output stage,
  // so the switch is delayed to match
  always_ff @(posedge clk) begin
    if (reset) begin
      pc_q <= 1'b0;
    end else begin
      pc_q <= pc_next;
    end
  end

  // drop at once when the mode leaves az
  assign pc_sw = pc_q & enable;

  // monitor, phase count low bits above pc and phase
  assign mon = {count[5:0], pc_next, phase};

endmodule

// ==== mode_output.sv ====
/*
  mode output stage
  registers off, register, counter or auto-zero value by mode,
  with a free running test counter of the payload width
*/

`timescale 1ns/1ns

module mode_output import dmm_pkg::*; #(
  parameter type      payload_t = logic [7:0],
  parameter payload_t safe      = '0
) (
  input  logic     clk,
  input  logic     reset,
  input  mode_t    mode,
  input  payload_t reg_value,
  input  payload_t az_value,
  output payload_t out
);

  payload_t count;

  // test counter, runs only in counter mode
  always_ff @(posedge clk) begin
    if (reset || mode != mode_count) begin
      count <= '0;
    end else begin
      count <= payload_t'(count + 1'b1);
    end
  end

  // one register stage on the pins
  always_ff @(posedge clk) begin
    if (reset) begin
      out <= safe;
    end else begin
      case (mode)
        mode_reg:   out <= reg_value;
        mode_count: out <= count;
        mode_az:    out <= az_value;
        default:    out <= safe;
      endcase
    end
  end

endmodule

// ==== top.sv ====
/*
  dmm control top level
  spi register bank and 4094 routing, mode selected mux and monitor pins
*/

`timescale 1ns/1ns

module top import dmm_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  // host spi
  input  logic     spi_clk,
  input  logic     spi_cs,
  input  logic     spi_cs2,
  input  logic     spi_mosi,
  output logic     spi_miso,
  // 4094 chain
  input  logic     u1004_4094_data,
  output logic     glb_4094_clk,
  output logic     glb_4094_data,
  output logic     glb_4094_strobe,
  output logic     oe_4094,
  // front end
  output logic     led0,
  output mon_t     mon,
  output mux_ctl_t mux_ctl,
  output logic     pc_sw
);

  logic     reg_dout;
  logic     spi_mux_en;
  mode_t    mode;
  mux_ctl_t mux_ctl_reg;
  period_t  az_period;
  mux_ctl_t az_mux_ctl;
  mon_t     az_mon;

  ////////////////////////////////////////
  // spi side

  spi_reg_bank reg_bank (
    .clk         (clk),
    .reset       (reset),
    .sclk        (spi_clk),
    .cs          (spi_cs),
    .mosi        (spi_mosi),
    .dout        (reg_dout),
    .led         (led0),
    .spi_mux_en  (spi_mux_en),
    .mode        (mode),
    .mux_ctl_reg (mux_ctl_reg),
    .az_period   (az_period)
  );

  spi_mux spi_route (
    .spi_mux_en  (spi_mux_en),
    .cs2         (spi_cs2),
    .sclk        (spi_clk),
    .mosi        (spi_mosi),
    .dout        (reg_dout),
    .vec_miso    (u1004_4094_data),
    .miso        (spi_miso),
    .strobe_4094 (glb_4094_strobe),
    .clk_4094    (glb_4094_clk),
    .data_4094   (glb_4094_data)
  );

  // 4094 outputs always driven
  assign oe_4094 = 1'b1;

  ////////////////////////////////////////
  // mux and monitor pins

  az_modulator az_mod (
    .clk        (clk),
    .reset      (reset),
    .enable     (mode == mode_az),
    .period     (az_period),
    .az_mux_ctl (az_mux_ctl),
    .pc_sw      (pc_sw),
    .mon        (az_mon)
  );

  mode_output #(.payload_t(mux_ctl_t), .safe(mux_ctl_safe)) mux_out (
    .clk       (clk),
    .reset     (reset),
    .mode      (mode),
    .reg_value (mux_ctl_reg),
    .az_value  (az_mux_ctl),
    .out       (mux_ctl)
  );

  // in register mode the monitor shows the low byte of the mux word
  mode_output #(.payload_t(mon_t), .safe(mon_safe)) mon_out (
    .clk       (clk),
    .reset     (reset),
    .mode      (mode),
    .reg_value (mux_ctl_reg[7:0]),
    .az_value  (az_mon),
    .out       (mon)
  );

endmodule

// ==== top_properties.sv ====
/*
  top level properties
  safe mux pins in mode off, precharge only in auto-zero, 4094 strobe idle
*/

`timescale 1ns/1ns

module top_properties import dmm_pkg::*; (
  input logic     clk,
  input logic     reset,
  input mode_t    mode,
  input mux_ctl_t mux_ctl,
  input logic     pc_sw,
  input logic     spi_cs2,
  input logic     glb_4094_strobe
);

  // pins lag the mode by the output register
  mux_safe_in_off: assert property (@(posedge clk) disable iff (reset)
    (mode == mode_off && $past(mode) == mode_off) |-> mux_ctl == mux_ctl_safe)
    else $error("mux pins left the safe value while the mode is off");

  // precharge switch drops with the mode, no lag
  pc_only_in_az: assert property (@(posedge clk) disable iff (reset)
    mode != mode_az |-> !pc_sw)
    else $error("pc_sw high outside auto-zero mode");

  strobe_idle: assert property (@(posedge clk) disable iff (reset)
    spi_cs2 |-> !glb_4094_strobe)
    else $error("4094 strobe high while cs2 is deasserted");

endmodule

bind top top_properties props (
  .clk             (clk),
  .reset           (reset),
  .mode            (mode),
  .mux_ctl         (mux_ctl),
  .pc_sw           (pc_sw),
  .spi_cs2         (spi_cs2),
  .glb_4094_strobe (glb_4094_strobe)
);

// ==== tb_top.sv ====
/*
  dmm control testbench
  reads operations from the vectors file, drives the host spi and the 4094 lines,
  checks register round trips, 4094 routing and the four output modes
*/

`timescale 1ns/1ns

module tb_top import dmm_pkg::*;;

  logic     clk = 1'b0;
  logic     reset;
  logic     spi_clk;
  logic     spi_cs;
  logic     spi_cs2;
  logic     spi_mosi;
  logic     spi_miso;
  logic     u1004_4094_data;
  logic     glb_4094_clk;
  logic     glb_4094_data;
  logic     glb_4094_strobe;
  logic     oe_4094;
  logic     led0;
  mon_t     mon;
  mux_ctl_t mux_ctl;
  logic     pc_sw;

  // 4 ns clock
  always #2 clk = ~clk;

  top dut (
    .clk             (clk),
    .reset           (reset),
    .spi_clk         (spi_clk),
    .spi_cs          (spi_cs),
    .spi_cs2         (spi_cs2),
    .spi_mosi        (spi_mosi),
    .spi_miso        (spi_miso),
    .u1004_4094_data (u1004_4094_data),
    .glb_4094_clk    (glb_4094_clk),
    .glb_4094_data   (glb_4094_data),
    .glb_4094_strobe (glb_4094_strobe),
    .oe_4094         (oe_4094),
    .led0            (led0),
    .mon             (mon),
    .mux_ctl         (mux_ctl),
    .pc_sw           (pc_sw)
  );

  ////////////////////////////////////////
  // reporting and compares

  task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("ERROR %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_mux(input string name, input mux_ctl_t exp, input mux_ctl_t act);
    if (act !== exp) begin
      $display("ERROR %s mux pins expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_mon(input string name, input mon_t exp, input mon_t act);
    if (act !== exp) begin
      $display("ERROR %s monitor expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR %s expected %b actual %b", name, exp, act);
      abort_run();
    end
  endtask

  // length of one az phase in clk cycles
  task automatic check_run(input string name, input period_t exp, input period_t act);
    if (act !== exp) begin
      $display("ERROR %s az phase length expected %0d actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  ////////////////////////////////////////
  // spi host

  // one spi half period is 8 clk cycles
  task automatic wait_half();
    repeat (8) @(negedge clk);
  endtask

  // mode 0 frame under cs with msb first
  // a frame of any length other than 32 writes nothing
  task automatic spi_frame(input addr_t addr, input data_t wdata, input int nbits,
                           output data_t rdata);
    logic [31:0] word;
    word   = {addr, wdata};
    rdata  = '0;
    spi_cs = 1'b0;
    wait_half();
    for (int i = 0; i < nbits; i++) begin
      spi_mosi = (i < 32) ? word[31 - i] : 1'b0;
      wait_half();
      // old register value is on miso ahead of each data bit edge
      if (i >= 8 && i < 32) begin
        rdata = {rdata[22:0], spi_miso};
      end
      spi_clk = 1'b1;
      wait_half();
      spi_clk = 1'b0;
    end
    wait_half();
    spi_cs   = 1'b1;
    spi_mosi = 1'b0;
    // write lands within 5 cycles and the output stage adds one
    wait_half();
  endtask

  // frame under cs2 with a random chain readback per bit
  task automatic chain_transfer(input string name, input int nbits, input data_t bits,
                                input logic routed);
    logic [31:0] rnd;
    logic        bit_out;
    logic        readback;
    spi_cs2 = 1'b0;
    wait_half();
    for (int i = nbits - 1; i >= 0; i--) begin
      rnd             = $urandom();
      bit_out         = bits[i];
      readback        = rnd[0];
      spi_mosi        = bit_out;
      u1004_4094_data = readback;
      wait_half();
      check_bit({name, " strobe"}, routed, glb_4094_strobe);
      check_bit({name, " clock low"}, 1'b0, glb_4094_clk);
      check_bit({name, " data"}, routed & bit_out, glb_4094_data);
      check_bit({name, " miso"}, routed & readback, spi_miso);
      spi_clk = 1'b1;
      wait_half();
      // the 4094 shifts on this edge
      check_bit({name, " clock high"}, routed, glb_4094_clk);
      check_bit({name, " data at clock"}, routed & bit_out, glb_4094_data);
      spi_clk = 1'b0;
    end
    wait_half();
    spi_cs2         = 1'b1;
    spi_mosi        = 1'b0;
    u1004_4094_data = 1'b0;
    wait_half();
    check_bit({name, " strobe idle"}, 1'b0, glb_4094_strobe);
    check_bit({name, " data idle"}, 1'b0, glb_4094_data);
  endtask

  ////////////////////////////////////////
  // mode checks

  // long enough to see the monitor wrap
  task automatic check_counting(input string name);
    mux_ctl_t last_mux;
    mon_t     last_mon;
    last_mux = mux_ctl;
    last_mon = mon;
    repeat (300) begin
      @(negedge clk);
      check_mux(name, mux_ctl_t'(last_mux + 1'b1), mux_ctl);
      check_mon(name, mon_t'(last_mon + 1'b1), mon);
      last_mux = mux_ctl;
      last_mon = mon;
    end
  endtask

  // the first run is partial and the next four must last p+1 each
  task automatic check_az(input string name, input period_t p);
    logic [3:0] last;
    logic       zero;
    logic [5:0] phase_count;
    int         run;
    int         runs;
    int         cycles;
    int         limit;
    last   = mux_ctl[3:0];
    run    = 1;
    runs   = 0;
    cycles = 0;
    limit  = (int'(p) + 1) * 8 + 64;
    while (runs < 5) begin
      if (cycles > limit) begin
        $display("%s: the az mux code stopped changing", name);
        abort_run();
      end
      @(negedge clk);
      cycles++;
      zero = (mux_ctl[3:0] == az_code_zero);
      // hi muxes stay disabled and the az field holds one of the two codes
      check_mux(name, {mux_ctl_safe[11:4], zero ? az_code_zero : az_code_signal}, mux_ctl);
      check_bit({name, " pc_sw"}, zero, pc_sw);
      if (mux_ctl[3:0] != last) begin
        if (runs > 0) begin
          check_run(name, period_t'(p + 1'b1), period_t'(run));
        end
        runs++;
        run  = 1;
        last = mux_ctl[3:0];
      end else begin
        run++;
      end
      // monitor from the top down is phase count, pc_sw and phase
      if (runs > 0) begin
        phase_count = 6'(run - 1);
        check_mon({name, " monitor"}, {phase_count, zero, ~zero}, mon);
      end
    end
  endtask

  task automatic run_mode(input string name, input addr_t addr, input data_t data,
                          input data_t expected);
    data_t old;
    spi_frame(addr, data, 32, old);
    case (mode_t'(data[1:0]))
      mode_off: begin
        check_mux(name, mux_ctl_safe, mux_ctl);
        check_mon(name, mon_safe, mon);
        check_bit({name, " pc_sw"}, 1'b0, pc_sw);
      end
      mode_reg: begin
        // monitor shows the low byte of the mux word
        check_mux(name, mux_ctl_t'(expected[11:0]), mux_ctl);
        check_mon(name, mon_t'(expected[7:0]), mon);
      end
      mode_count: check_counting(name);
      default:    check_az(name, period_t'(expected[15:0]));
    endcase
  endtask

  task automatic run_vector(input int line_no, input string op, input addr_t addr,
                            input data_t data, input data_t expected);
    string name;
    data_t rdata;
    data_t rnd;
    name = $sformatf("line %0d %s %h", line_no, op, addr);
    if (op == "write") begin
      spi_frame(addr, data, 32, rdata);
      check_data({name, " old value"}, expected, rdata);
    end else if (op == "read") begin
      // a 33 bit frame writes nothing back
      spi_frame(addr, '0, 33, rdata);
      check_data(name, expected, rdata);
    end else if (op == "rand") begin
      rnd = data_t'($urandom());
      spi_frame(addr, rnd, 32, rdata);
      check_data({name, " old value"}, expected, rdata);
      spi_frame(addr, '0, 33, rdata);
      check_data({name, " readback"}, rnd & data, rdata);
      spi_frame(addr, '0, 32, rdata);
      check_data({name, " clear"}, rnd & data, rdata);
    end else if (op == "led") begin
      check_bit(name, expected[0], led0);
    end else if (op == "mode") begin
      run_mode(name, addr, data, expected);
    end else if (op == "xfer") begin
      chain_transfer(name, int'(addr), data, expected[0]);
    end else begin
      $display("unknown operation %s on line %0d of the vectors file", op, line_no);
      abort_run();
    end
  endtask

  ////////////////////////////////////////
  // main sequence

  initial begin
    string line;
    string op;
    addr_t addr;
    data_t data;
    data_t expected;
    int    fd;
    int    fields;
    int    line_no;
    reset           = 1'b1;
    spi_clk         = 1'b0;
    spi_cs          = 1'b1;
    spi_cs2         = 1'b1;
    spi_mosi        = 1'b0;
    u1004_4094_data = 1'b0;
    line_no         = 0;
    void'($urandom(32'hd8e2_43f4));
    repeat (3) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    // reset state of the pins
    check_mux("reset", mux_ctl_safe, mux_ctl);
    check_mon("reset", mon_safe, mon);
    check_bit("reset pc_sw", 1'b0, pc_sw);
    check_bit("reset led0", 1'b0, led0);
    check_bit("reset 4094 strobe", 1'b0, glb_4094_strobe);
    check_bit("reset 4094 clock", 1'b0, glb_4094_clk);
    check_bit("reset 4094 data", 1'b0, glb_4094_data);
    check_bit("reset 4094 oe", 1'b1, oe_4094);
    check_bit("reset miso", 1'b0, spi_miso);
    fd = $fopen("top_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open top_vectors.txt");
      abort_run();
    end
    while ($fgets(line, fd) != 0) begin
      line_no++;
      if (line.len() > 1 && line[0] != "#") begin
        fields = $sscanf(line, "%s %h %h %h", op, addr, data, expected);
        if (fields != 4) begin
          $display("line %0d of the vectors file does not have four fields", line_no);
          abort_run();
        end
        run_vector(line_no, op, addr, data, expected);
      end
    end
    $fclose(fd);
    $display("TESTS PASSED");
    $finish;
  end

  // whole run limit
  initial begin
    #500_000;
    $display("the run did not finish in time");
    abort_run();
  end

endmodule

// ==== top_vectors.txt ====
# op    addr  data    expected   (addr, data and expected in hex)
# write: 32 bit frame, expected is the old value on miso; read: 33 bit frame, no write
# rand: random data, read back masked by data, then cleared; led: expected bit 0 on led0
# mode: data written to addr, expected is the mux word (reg) or period (az)
# xfer: cs2 frame, addr is the bit count, expected 1 when routed to the 4094 chain
write 01 5a5a5b 000000
read  01 000000 5a5a5b
led   00 000000 000001
write 01 000100 5a5a5b
led   00 000000 000000
write 07 123456 000000
read  07 000000 000000
read  00 000000 000000
rand  05 ffffff 000000
rand  09 000000 000000
write 04 abc7e5 000000
read  04 000000 abc7e5
mode  03 000001 0007e5
mode  03 000000 000000
mode  03 000002 000000
mode  03 000000 000000
write 05 000003 000000
mode  03 000003 000003
mode  03 000000 000000
write 05 000009 000003
mode  03 000003 000009
mode  03 000000 000000
read  05 000000 000009
xfer  10 00a5c3 000000
write 02 000001 000000
xfer  10 00a5c3 000001
xfer  08 00003c 000001
write 02 000000 000001
xfer  08 0000ff 000000

// ==== files.f ====
dmm_pkg.sv
spi_reg_bank.sv
spi_mux.sv
az_modulator.sv
mode_output.sv
top.sv
top_properties.sv
tb_top.sv

// ==== Makefile ====
# verilator build and run of the dmm control testbench

SIM      = verilator
TOP      = tb_top
FILELIST = files.f
FLAGS    = --binary --timing --assert
BIN      = obj_dir/V$(TOP)
SRCS     = $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# exit status is nonzero on a failed run
run: $(BIN) top_vectors.txt
	./$(BIN)

clean:
	rm -rf obj_dir
